// File: bm_bus_pkg.sv
// bus-side widths, store geometry and command opcodes shared by the byte merge store
package bm_bus_pkg;

    // word and byte-lane geometry
    localparam int DATA_W = 32;
    localparam int LANES  = 4;
    localparam int LANE_W = DATA_W / LANES;

    // store size, one address per stored word
    localparam int DEPTH  = 4;
    localparam int ADDR_W = 2;

    // opcode carried on the command port and the command channel
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } bm_op_e;

endpackage

// File: bm_ctrl_pkg.sv
// controller state encodings for the requester, merge buffer and responder FSMs
package bm_ctrl_pkg;

    // command requester
    typedef enum logic [1:0] {
        RQ_IDLE,
        RQ_REQ,
        RQ_RELEASE
    } rq_state_e;

    // merge buffer, write path and read path share the idle and release states
    typedef enum logic [2:0] {
        BF_IDLE,
        BF_MERGE,
        BF_COMMIT,
        BF_RSP_REQ,
        BF_RSP_DROP,
        BF_ACK,
        BF_WAIT_DROP
    } bf_state_e;

    // read responder
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_ACK,
        RS_HOLD
    } rs_state_e;

endpackage

// File: bm_chan_if.sv
// four-phase req/ack channels used between the requester, buffer and responder
`timescale 1ns/100ps

// command channel, requester to buffer
interface bm_cmd_if
    import bm_bus_pkg::*;
();
    logic              req;
    logic              ack;
    bm_op_e            op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [LANES-1:0]  byte_en;

    modport requester (
        output req, op, addr, wdata, byte_en,
        input  ack
    );

    modport buffer (
        input  req, op, addr, wdata, byte_en,
        output ack
    );
endinterface

// response channel, buffer to responder
interface bm_rsp_if
    import bm_bus_pkg::*;
();
    logic              req;
    logic              ack;
    logic [DATA_W-1:0] rdata;
    logic [ADDR_W-1:0] raddr;

    modport buffer (
        output req, rdata, raddr,
        input  ack
    );

    modport responder (
        input  req, rdata, raddr,
        output ack
    );
endinterface

// File: command_requester.sv
// producer: takes valid/ready commands and issues each one as a four-phase request
`timescale 1ns/100ps

module command_requester
    import bm_bus_pkg::*;
    import bm_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  bm_op_e            cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  logic [LANES-1:0]  cmd_byte_en,
    output logic              cmd_ready,
    bm_cmd_if.requester       cmd
);

    rq_state_e state;
    logic      accept;

    assign accept = cmd_valid && cmd_ready;

    // handshake sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RQ_IDLE;
            cmd_ready <= 1'b0;
            cmd.req   <= 1'b0;
        end else begin
            case (state)
                RQ_IDLE: begin
                    if (accept) begin
                        cmd_ready <= 1'b0;
                        cmd.req   <= 1'b1;
                        state     <= RQ_REQ;
                    end else begin
                        cmd_ready <= 1'b1;
                    end
                end
                RQ_REQ: begin
                    // target has the command, withdraw
                    if (cmd.ack) begin
                        cmd.req <= 1'b0;
                        state   <= RQ_RELEASE;
                    end
                end
                RQ_RELEASE: begin
                    // ready again only once ack is back low
                    if (!cmd.ack) begin
                        cmd_ready <= 1'b1;
                        state     <= RQ_IDLE;
                    end
                end
                default: state <= RQ_IDLE;
            endcase
        end
    end

    // command fields, loaded only on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.op      <= cmd_op;
            cmd.addr    <= cmd_addr;
            cmd.wdata   <= cmd_wdata;
            cmd.byte_en <= cmd_byte_en;
        end
    end

    // fields hold from req rise until ack has fallen
    a_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.req || cmd.ack) |=>
            !(cmd.req || cmd.ack) || $stable({cmd.op, cmd.addr, cmd.wdata, cmd.byte_en}))
        else $error("command fields changed during a handshake");

    // a new request only after the previous ack dropped
    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd.req) |-> !cmd.ack)
        else $error("cmd req rose while ack was still high");

endmodule

// File: byte_merge_buffer.sv
// four-word store with byte-lane write merge and a read path over the response channel
`timescale 1ns/100ps

module byte_merge_buffer
    import bm_bus_pkg::*;
    import bm_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    bm_cmd_if.buffer cmd,
    bm_rsp_if.buffer rsp
);

    bf_state_e         state;
    logic [DATA_W-1:0] store [DEPTH];

    // write pipeline registers
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [LANES-1:0]  be_q;
    logic [DATA_W-1:0] merged_d;
    logic [DATA_W-1:0] merged_q;

    // lane select between incoming byte and stored byte
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            merged_d[i*LANE_W +: LANE_W] = be_q[i] ? wdata_q[i*LANE_W +: LANE_W]
                                                   : store[addr_q][i*LANE_W +: LANE_W];
        end
    end

    // control and both handshakes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= BF_IDLE;
            cmd.ack <= 1'b0;
            rsp.req <= 1'b0;
        end else begin
            case (state)
                BF_IDLE: begin
                    if (cmd.req && !cmd.ack) begin
                        state <= BF_MERGE;
                    end
                end
                BF_MERGE: begin
                    if (cmd.op == OP_WRITE) begin
                        state <= BF_COMMIT;
                    end else begin
                        // read data is loaded on this same edge
                        rsp.req <= 1'b1;
                        state   <= BF_RSP_REQ;
                    end
                end
                BF_COMMIT: begin
                    state <= BF_ACK;
                end
                BF_ACK: begin
                    // store is written on this edge too
                    cmd.ack <= 1'b1;
                    state   <= BF_WAIT_DROP;
                end
                BF_RSP_REQ: begin
                    // stalls here while the responder holds an older result
                    if (rsp.ack) begin
                        rsp.req <= 1'b0;
                        state   <= BF_RSP_DROP;
                    end
                end
                BF_RSP_DROP: begin
                    if (!rsp.ack) begin
                        cmd.ack <= 1'b1;
                        state   <= BF_WAIT_DROP;
                    end
                end
                BF_WAIT_DROP: begin
                    if (!cmd.req) begin
                        cmd.ack <= 1'b0;
                        state   <= BF_IDLE;
                    end
                end
                default: state <= BF_IDLE;
            endcase
        end
    end

    // capture stage, then merge stage
    always_ff @(posedge clk) begin
        if (state == BF_MERGE) begin
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
            be_q    <= cmd.byte_en;
        end
        if (state == BF_COMMIT) begin
            merged_q <= merged_d;
        end
    end

    // read result, stable for the whole response handshake
    always_ff @(posedge clk) begin
        if (state == BF_MERGE && cmd.op == OP_READ) begin
            rsp.rdata <= store[cmd.addr];
            rsp.raddr <= cmd.addr;
        end
    end

    // word store, zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                store[i] <= '0;
            end
        end else if (state == BF_ACK) begin
            store[addr_q] <= merged_q;
        end
    end

    a_ack_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd.ack) |-> cmd.req)
        else $error("cmd ack rose without a pending req");

    // the response channel only serves reads
    a_rsp_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp.req) |-> cmd.req && cmd.op == OP_READ)
        else $error("rsp req rose outside a read command");

endmodule

// File: read_responder.sv
// consumer: accepts response transfers into a one-entry hold and offers them valid/ready
`timescale 1ns/100ps

module read_responder
    import bm_bus_pkg::*;
    import bm_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    bm_rsp_if.responder       rsp,
    input  logic              rsp_ready,
    output logic              rsp_valid,
    output logic [DATA_W-1:0] rsp_data,
    output logic [ADDR_W-1:0] rsp_addr
);

    rs_state_e state;
    logic      take;

    // new transfer only with the entry empty and the last ack gone
    assign take = (state == RS_IDLE) && rsp.req && !rsp.ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RS_IDLE;
            rsp.ack   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            // release phase runs independently of the entry
            if (rsp.ack && !rsp.req) begin
                rsp.ack <= 1'b0;
            end
            case (state)
                RS_IDLE: begin
                    if (take) begin
                        rsp.ack <= 1'b1;
                        state   <= RS_ACK;
                    end
                end
                RS_ACK: begin
                    rsp_valid <= 1'b1;
                    state     <= RS_HOLD;
                end
                RS_HOLD: begin
                    if (rsp_ready) begin
                        rsp_valid <= 1'b0;
                        state     <= RS_IDLE;
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

    // holding register
    always_ff @(posedge clk) begin
        if (take) begin
            rsp_data <= rsp.rdata;
            rsp_addr <= rsp.raddr;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable({rsp_data, rsp_addr}))
        else $error("response dropped or changed before it was taken");

endmodule

// File: byte_merge_top.sv
// top level of the byte merge store: command port in, response port out
`timescale 1ns/100ps

module byte_merge_top
    import bm_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // command port
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  bm_op_e            cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_wdata,
    input  logic [LANES-1:0]  cmd_byte_en,

    // response port
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_data,
    output logic [ADDR_W-1:0] rsp_addr
);

    bm_cmd_if i_cmd_if ();
    bm_rsp_if i_rsp_if ();

    command_requester i_command_requester (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_byte_en (cmd_byte_en),
        .cmd_ready   (cmd_ready),
        .cmd         (i_cmd_if.requester)
    );

    byte_merge_buffer i_byte_merge_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (i_cmd_if.buffer),
        .rsp   (i_rsp_if.buffer)
    );

    read_responder i_read_responder (
        .clk       (clk),
        .rst_n     (rst_n),
        .rsp       (i_rsp_if.responder),
        .rsp_ready (rsp_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_addr  (rsp_addr)
    );

endmodule

// File: tb_byte_merge.sv
// testbench for the byte merge store: drives commands, models the store, checks every response
`timescale 1ns/100ps

module tb_byte_merge
    import bm_bus_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    logic              cmd_ready;
    bm_op_e            cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_wdata;
    logic [LANES-1:0]  cmd_byte_en;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [DATA_W-1:0] rsp_data;
    logic [ADDR_W-1:0] rsp_addr;

    // reference store and the reads still owed, oldest first
    logic [DATA_W-1:0]        model_mem [DEPTH];
    logic [ADDR_W+DATA_W-1:0] exp_q [$];
    logic                     head_valid;
    logic [DATA_W-1:0]        head_data;
    logic [ADDR_W-1:0]        head_addr;

    string test_name;
    logic  rand_ready;
    logic  bp_hold;

    byte_merge_top i_byte_merge_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_byte_en (cmd_byte_en),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_data    (rsp_data),
        .rsp_addr    (rsp_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    // each enabled byte comes from the new word, the rest from the old one
    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [LANES-1:0]  be);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int i = 0; i < LANES; i++) begin
            if (be[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic refresh_head();
        head_valid = (exp_q.size() > 0);
        if (head_valid) begin
            {head_addr, head_data} = exp_q[0];
        end
    endtask

    // offer one command and update the model on the edge that takes it
    task automatic issue(input bm_op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data, input logic [LANES-1:0] be);
        logic taken;
        int   waited;
        taken       = 1'b0;
        waited      = 0;
        cmd_valid   = 1'b1;
        cmd_op      = op;
        cmd_addr    = addr;
        cmd_wdata   = data;
        cmd_byte_en = be;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            taken  = cmd_ready;
            waited = waited + 1;
            if (taken && op == OP_WRITE) begin
                model_mem[addr] = merge_lanes(model_mem[addr], data, be);
            end else if (taken) begin
                exp_q.push_back({addr, model_mem[addr]});
                refresh_head();
            end
            #1;
            if (taken) begin
                cmd_valid = 1'b0;
            end
            if (rand_ready) begin
                rsp_ready = 1'($urandom_range(0, 1));
            end
        end
        if (!taken) begin
            stop_on_error("timeout: command was not accepted");
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((head_valid || rsp_valid) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
        end
        if (head_valid || rsp_valid) begin
            stop_on_error("timeout: read responses did not all arrive");
        end
    endtask

    task automatic wait_valid();
        int waited;
        waited = 0;
        while (!rsp_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited = waited + 1;
        end
        if (!rsp_valid) begin
            stop_on_error("timeout: rsp_valid never rose");
        end
    endtask

    // retire the expected entry when a response is taken
    always @(posedge clk) begin
        if (rst_n && rsp_valid && rsp_ready && head_valid) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !cmd_ready && !rsp_valid)
        else stop_on_error("cmd_ready or rsp_valid was high during reset");

    a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> cmd_ready)
        else stop_on_error("cmd_ready did not rise one cycle after reset");

    a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> head_valid)
        else stop_on_error("a response arrived with no read outstanding");

    a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready && head_valid |-> rsp_data == head_data)
        else stop_on_error($sformatf("FAILED %s: expected data %h, actual %h",
                                     test_name, $sampled(head_data), $sampled(rsp_data)));

    a_rsp_addr: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready && head_valid |-> rsp_addr == head_addr)
        else stop_on_error($sformatf("FAILED %s: expected addr %h, actual %h",
                                     test_name, $sampled(head_addr), $sampled(rsp_addr)));

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_addr))
        else stop_on_error("held response dropped or changed while rsp_ready was low");

    a_read_stalled: assert property (@(posedge clk) disable iff (!rst_n) bp_hold |-> !cmd_ready)
        else stop_on_error("cmd_ready rose while a read was stalled behind a held response");

    initial begin
        logic [LANES-1:0]  be_set [5];
        bm_op_e            r_op;
        logic [ADDR_W-1:0] r_addr;
        logic [DATA_W-1:0] r_data;
        logic [LANES-1:0]  r_be;
        void'($urandom(32'hfed40f78));
        be_set      = '{4'b0001, 4'b0100, 4'b1010, 4'b0110, 4'b1000};
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_op      = OP_WRITE;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        cmd_byte_en = '0;
        rsp_ready   = 1'b0;
        rand_ready  = 1'b0;
        bp_hold     = 1'b0;
        head_valid  = 1'b0;
        head_data   = '0;
        head_addr   = '0;
        test_name   = "reset";
        for (int a = 0; a < DEPTH; a++) begin
            model_mem[a] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_name = "reset_contents";
        rsp_ready = 1'b1;
        for (int a = 0; a < DEPTH; a++) begin
            issue(OP_READ, ADDR_W'(a), '0, '0);
        end
        drain();

        test_name = "full_write";
        issue(OP_WRITE, 2'd1, 32'ha5c3_1e77, 4'hf);
        issue(OP_READ, 2'd1, '0, '0);
        drain();

        // known word, then lane patterns over it
        test_name = "partial_merge";
        issue(OP_WRITE, 2'd2, 32'h1122_3344, 4'hf);
        for (int k = 0; k < 5; k++) begin
            issue(OP_WRITE, 2'd2, 32'hdead_beef + k * 32'h0101_0101, be_set[k]);
            issue(OP_READ, 2'd2, '0, '0);
        end
        drain();

        test_name = "address_isolation";
        for (int a = 0; a < DEPTH; a++) begin
            issue(OP_WRITE, ADDR_W'(a), 32'h5a00_0000 + a * 32'h0011_2233, 4'hf);
        end
        issue(OP_WRITE, 2'd0, 32'hffff_ffff, 4'b0101);
        issue(OP_WRITE, 2'd0, 32'h0000_0000, 4'b1000);
        for (int a = 0; a < DEPTH; a++) begin
            issue(OP_READ, ADDR_W'(a), '0, '0);
        end
        drain();

        // one result held, a write slips past, a second read stalls
        test_name = "back_pressure";
        rsp_ready = 1'b0;
        issue(OP_READ, 2'd2, '0, '0);
        wait_valid();
        repeat (4) @(posedge clk);
        #1;
        issue(OP_WRITE, 2'd3, 32'h0f1e_2d3c, 4'b0011);
        issue(OP_READ, 2'd3, '0, '0);
        // longer than an unstalled read takes to free the command port
        bp_hold = 1'b1;
        repeat (20) @(posedge clk);
        #1;
        bp_hold   = 1'b0;
        rsp_ready = 1'b1;
        drain();

        test_name  = "random_mix";
        rand_ready = 1'b1;
        repeat (60) begin
            r_op   = bm_op_e'($urandom_range(0, 1));
            r_addr = ADDR_W'($urandom_range(0, DEPTH - 1));
            r_data = $urandom;
            r_be   = LANES'($urandom_range(0, 15));
            issue(r_op, r_addr, r_data, r_be);
        end
        rand_ready = 1'b0;
        rsp_ready  = 1'b1;
        drain();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: sim.f
bm_bus_pkg.sv
bm_ctrl_pkg.sv
bm_chan_if.sv
command_requester.sv
byte_merge_buffer.sv
read_responder.sv
byte_merge_top.sv
tb_byte_merge.sv
